//--- bench/frontend_checker.sv
`default_nettype none

module frontend_checker (
    input logic                        clk,
    input logic                        rst,
    input logic                        out_valid,
    input logic                        dn_credit,
    input logic [fe_pkg::credit_w-1:0] fetch_credits
);
    import fe_pkg::*;

    int assert_failures = 0;

    // Downstream credits as decode has granted them, independent of the queue
    int dn_avail;

    always_ff @(posedge clk) begin
        if (rst) begin
            dn_avail <= dn_credits;
        end else begin
            dn_avail <= dn_avail - int'(out_valid) + int'(dn_credit);
        end
    end

    // A word only leaves against a downstream credit
    send_needs_credit: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> (dn_avail > 0)
    ) else begin
        $error("out_valid high while decode has granted no credit");
        assert_failures++;
    end

    // Fetch never holds more credits than queue slots
    credit_bound: assert property (
        @(posedge clk) disable iff (rst) fetch_credits <= credit_w'(queue_depth)
    ) else begin
        $error("fetch credit count above the queue depth");
        assert_failures++;
    end

    idle_after_reset: assert property (
        @(posedge clk) rst |=> !out_valid
    ) else begin
        $error("out_valid high in the cycle after reset");
        assert_failures++;
    end

endmodule

bind frontend_top frontend_checker i_checker (
    .clk(clk),
    .rst(rst),
    .out_valid(out_valid),
    .dn_credit(dn_credit),
    .fetch_credits(i_fetch.credits)
);

`default_nettype wire

//--- bench/frontend_tb.sv
`default_nettype none

module frontend_tb;
    import fe_pkg::*;

    localparam int clk_period    = 40;
    localparam int drive_dly     = 2;
    localparam int n_rows        = 14;
    localparam int n_prog        = 12;
    localparam int hold_cycles   = 40;
    localparam int phase1_words  = 25;
    localparam int phase2_words  = 6;
    localparam int watchdog_time = n_rows * 60 * clk_period;
    localparam logic [31:0] phase2_pc = 32'h80;

    logic                 clk, rst, ld_req, redir_valid, dn_credit, out_valid;
    logic [xlen-1:0]      ld_addr, ld_data, redir_pc, out_inst, out_pc, out_pred_pc;
    logic [br_type_w-1:0] out_br_type;

    // Program table with the expected class and predicted next PC of each word
    logic [31:0] row_addr [n_rows];
    logic [31:0] row_inst [n_rows];
    logic [3:0]  row_br   [n_rows];
    logic [31:0] row_pred [n_rows];

    integer      seed = 73618;
    logic [31:0] rnd;
    logic [31:0] exp_pc = reset_pc;
    logic        hold_credits = 1'b0;
    int          err_count = 0;
    int          out_count = 0;
    int          pending = 0;
    int          hold_start;
    int          assert_fails;

    frontend_top i_dut (
        .clk, .rst, .ld_req, .ld_addr, .ld_data, .redir_valid, .redir_pc,
        .out_valid, .out_inst, .out_pc, .out_br_type, .out_pred_pc, .dn_credit
    );

    //////////////////////////////////////////////////////////////////////
    // Encoders and table
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] enc_off16(input logic [5:0] op, input int words);
        logic [31:0] offs;
        offs = words;
        // rj 4 and rd 5 fill the low bits
        return {op, offs[15:0], 10'h085};
    endfunction

    function automatic logic [31:0] enc_off26(input logic [5:0] op, input int words);
        logic [31:0] offs;
        offs = words;
        return {op, offs[15:0], offs[25:16]};
    endfunction

    task automatic set_row(input int i, input logic [31:0] addr, input logic [31:0] inst,
                           input logic [3:0] br, input logic [31:0] pred);
        row_addr[i] = addr;
        row_inst[i] = inst;
        row_br[i]   = br;
        row_pred[i] = pred;
    endtask

    task automatic build_table();
        set_row(0,  32'h00, 32'h0280_0421,          4'd0,  32'h04);
        set_row(1,  32'h04, enc_off16(op_beq, 3),   4'd6,  32'h08);
        set_row(2,  32'h08, enc_off26(op_b, 4),     4'd4,  32'h18);
        // 0x0c and 0x10 lie in the shadow of the b and never leave the queue
        set_row(3,  32'h0c, 32'h1400_0005,          4'd0,  32'h10);
        set_row(4,  32'h10, 32'h1c00_0006,          4'd0,  32'h14);
        set_row(5,  32'h14, enc_off26(op_bl, 3),    4'd5,  32'h20);
        set_row(6,  32'h18, enc_off16(op_jirl, 5),  4'd3,  32'h1c);
        set_row(7,  32'h1c, enc_off16(op_bne, -2),  4'd7,  32'h14);
        set_row(8,  32'h20, enc_off16(op_blt, 2),   4'd8,  32'h24);
        set_row(9,  32'h24, enc_off16(op_bltu, 5),  4'd10, 32'h28);
        set_row(10, 32'h28, enc_off16(op_bge, 2),   4'd9,  32'h2c);
        set_row(11, 32'h2c, enc_off16(op_bgeu, -11), 4'd11, 32'h00);
        // Second block, written while fetch runs
        set_row(12, 32'h80, 32'h0280_0842,          4'd0,  32'h84);
        set_row(13, 32'h84, enc_off26(op_b, -1),    4'd4,  32'h80);
    endtask

    function automatic int find_row(input logic [31:0] pc);
        int found;
        found = -1;
        for (int i = 0; i < n_rows; i++) begin
            if (row_addr[i] == pc) begin
                found = i;
            end
        end
        return found;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus and checking tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_word();
        int idx;
        idx = find_row(exp_pc);
        if (idx < 0) begin
            $display("ERROR t=%0t the predicted path left the program at %h", $time, exp_pc);
            err_count++;
        end else begin
            check_field("out_pc", out_pc, exp_pc);
            check_field("out_inst", out_inst, row_inst[idx]);
            check_field("out_br_type", 32'(out_br_type), 32'(row_br[idx]));
            check_field("out_pred_pc", out_pred_pc, row_pred[idx]);
            exp_pc = row_pred[idx];
        end
    endtask

    task automatic load_rows(input int first, input int last);
        for (int i = first; i < last; i++) begin
            @(posedge clk);
            #drive_dly;
            ld_req  = 1'b1;
            ld_addr = row_addr[i];
            ld_data = row_inst[i];
        end
        @(posedge clk);
        #drive_dly;
        ld_req = 1'b0;
    endtask

    task automatic redirect_fetch(input logic [31:0] pc);
        @(posedge clk);
        #drive_dly;
        redir_valid = 1'b1;
        redir_pc    = pc;
        @(posedge clk);
        #drive_dly;
        redir_valid = 1'b0;
    endtask

    task automatic wait_words(input int n);
        do begin
            @(posedge clk);
        end while (out_count < n);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Decode model, credits go back only for words already taken
    initial begin
        dn_credit = 1'b0;
        forever begin
            @(posedge clk);
            #drive_dly;
            rnd = $random(seed);
            if (pending > 0 && !hold_credits && rnd[0]) begin
                dn_credit = 1'b1;
                pending--;
            end else begin
                dn_credit = 1'b0;
            end
            @(negedge clk);
            if (out_valid === 1'b1) begin
                check_word();
                out_count++;
                pending++;
            end
            if (redir_valid === 1'b1) begin
                exp_pc = redir_pc;
            end
        end
    end

    initial begin
        #(watchdog_time);
        $display("TIMEOUT: only %0d words reached decode", out_count);
        $display("tests failed");
        $finish;
    end

    initial begin
        rst         = 1'b1;
        ld_req      = 1'b0;
        ld_addr     = '0;
        ld_data     = '0;
        redir_valid = 1'b0;
        redir_pc    = '0;
        build_table();
        repeat (5) @(posedge clk);
        #drive_dly;
        rst = 1'b0;
        // Loader holds the port, then fetch starts at reset_pc
        load_rows(0, n_prog);
        redirect_fetch(reset_pc);
        repeat (3) @(posedge clk);
        load_rows(n_prog, n_rows);
        // Back-pressure stretch
        wait_words(8);
        hold_start   = out_count;
        hold_credits = 1'b1;
        repeat (hold_cycles) @(posedge clk);
        if (out_count - hold_start > dn_credits) begin
            $display("ERROR t=%0t %0d words went out with decode credits withheld",
                     $time, out_count - hold_start);
            err_count++;
        end
        hold_credits = 1'b0;
        wait_words(phase1_words);
        redirect_fetch(phase2_pc);
        wait_words(phase1_words + phase2_words);
        assert_fails = i_dut.i_checker.assert_failures;
        $display("words checked %0d, value errors %0d, assertion failures %0d",
                 out_count, err_count, assert_fails);
        if (err_count + assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/fe_pkg.sv
`default_nettype none

package fe_pkg;

    //////////////////////////////////////////////////////////////////////
    // Datapath and memory sizes
    //////////////////////////////////////////////////////////////////////

    localparam int xlen      = 32;
    localparam int mem_words = 256;
    localparam int mem_aw    = 8;

    localparam logic [xlen-1:0] reset_pc = '0;

    // Fetch queue and fetch credit sizing
    localparam int queue_depth   = 4;
    localparam int queue_aw      = $clog2(queue_depth);
    localparam int credit_w      = $clog2(queue_depth + 1);
    localparam int max_in_flight = 2;
    localparam int trk_aw        = $clog2(max_in_flight);

    // Credits granted by decode after reset
    localparam int dn_credits  = 2;
    localparam int dn_credit_w = $clog2(dn_credits + 1);

    //////////////////////////////////////////////////////////////////////
    // Major opcodes, bits 31:26 of the instruction word
    //////////////////////////////////////////////////////////////////////

    localparam int op_w = 6;

    localparam logic [op_w-1:0] op_jirl = 6'h13;
    localparam logic [op_w-1:0] op_b    = 6'h14;
    localparam logic [op_w-1:0] op_bl   = 6'h15;
    localparam logic [op_w-1:0] op_beq  = 6'h16;
    localparam logic [op_w-1:0] op_bne  = 6'h17;
    localparam logic [op_w-1:0] op_blt  = 6'h18;
    localparam logic [op_w-1:0] op_bge  = 6'h19;
    localparam logic [op_w-1:0] op_bltu = 6'h1a;
    localparam logic [op_w-1:0] op_bgeu = 6'h1b;

    //////////////////////////////////////////////////////////////////////
    // Branch type codes seen by decode
    //////////////////////////////////////////////////////////////////////

    localparam int br_type_w = 4;

    localparam logic [br_type_w-1:0] br_none = 4'd0;
    localparam logic [br_type_w-1:0] br_jirl = 4'd3;
    localparam logic [br_type_w-1:0] br_b    = 4'd4;
    localparam logic [br_type_w-1:0] br_bl   = 4'd5;
    localparam logic [br_type_w-1:0] br_beq  = 4'd6;
    localparam logic [br_type_w-1:0] br_bne  = 4'd7;
    localparam logic [br_type_w-1:0] br_blt  = 4'd8;
    localparam logic [br_type_w-1:0] br_bge  = 4'd9;
    localparam logic [br_type_w-1:0] br_bltu = 4'd10;
    localparam logic [br_type_w-1:0] br_bgeu = 4'd11;

endpackage

`default_nettype wire

//--- design/fetch_queue.sv
`default_nettype none

module fetch_queue (
    input  logic                         clk,
    input  logic                         rst,
    // From the fetch unit
    input  logic                         q_push,
    input  logic [fe_pkg::xlen-1:0]      q_inst,
    input  logic [fe_pkg::xlen-1:0]      q_pc,
    input  logic [fe_pkg::br_type_w-1:0] q_br_type,
    input  logic [fe_pkg::xlen-1:0]      q_pred_pc,
    output logic                         q_credit,
    input  logic                         flush,
    // Toward decode
    output logic                         out_valid,
    output logic [fe_pkg::xlen-1:0]      out_inst,
    output logic [fe_pkg::xlen-1:0]      out_pc,
    output logic [fe_pkg::br_type_w-1:0] out_br_type,
    output logic [fe_pkg::xlen-1:0]      out_pred_pc,
    input  logic                         dn_credit
);
    import fe_pkg::*;

    logic [xlen-1:0]      inst_q    [queue_depth];
    logic [xlen-1:0]      pc_q      [queue_depth];
    logic [br_type_w-1:0] br_type_q [queue_depth];
    logic [xlen-1:0]      pred_q    [queue_depth];

    logic [queue_aw-1:0]    wr_ptr;
    logic [queue_aw-1:0]    rd_ptr;
    logic [queue_aw:0]      count;
    logic [queue_aw:0]      refund;
    logic [dn_credit_w-1:0] dn_cnt;
    logic                   send;
    logic                   refund_pulse;

    // Nothing leaves in the cycle of a flush
    assign out_valid = (count != '0) && (dn_cnt != '0) && !flush;
    assign send      = out_valid;

    assign out_inst    = inst_q[rd_ptr];
    assign out_pc      = pc_q[rd_ptr];
    assign out_br_type = br_type_q[rd_ptr];
    assign out_pred_pc = pred_q[rd_ptr];

    // Flushed entries give their credit back one per cycle when no send does
    assign refund_pulse = (refund != '0) && !send;
    assign q_credit     = send || (refund != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            refund <= '0;
            dn_cnt <= dn_credit_w'(dn_credits);
        end else begin
            dn_cnt <= dn_cnt - dn_credit_w'(send) + dn_credit_w'(dn_credit);
            refund <= refund - (queue_aw+1)'(refund_pulse) + (flush ? count : '0);
            if (flush) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (q_push) begin
                    wr_ptr <= wr_ptr + queue_aw'(1);
                end
                if (send) begin
                    rd_ptr <= rd_ptr + queue_aw'(1);
                end
                count <= count + (queue_aw+1)'(q_push) - (queue_aw+1)'(send);
            end
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        if (q_push) begin
            inst_q[wr_ptr]    <= q_inst;
            pc_q[wr_ptr]      <= q_pc;
            br_type_q[wr_ptr] <= q_br_type;
            pred_q[wr_ptr]    <= q_pred_pc;
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  logic                         clk,
    input  logic                         rst,
    // Memory request through the arbiter
    output logic                         f_req,
    output logic [fe_pkg::xlen-1:0]      f_addr,
    input  logic                         f_gnt,
    input  logic                         f_rvalid,
    input  logic [fe_pkg::xlen-1:0]      f_rdata,
    // Pre-decoder
    output logic [fe_pkg::xlen-1:0]      pd_inst,
    output logic [fe_pkg::xlen-1:0]      pd_pc,
    input  logic [fe_pkg::br_type_w-1:0] pd_br_type,
    input  logic [fe_pkg::xlen-1:0]      pd_pred_pc,
    input  logic                         pd_redirect,
    // Fetch queue
    output logic                         q_push,
    output logic [fe_pkg::xlen-1:0]      q_inst,
    output logic [fe_pkg::xlen-1:0]      q_pc,
    output logic [fe_pkg::br_type_w-1:0] q_br_type,
    output logic [fe_pkg::xlen-1:0]      q_pred_pc,
    input  logic                         q_credit,
    // Back-end redirect
    input  logic                         redir_valid,
    input  logic [fe_pkg::xlen-1:0]      redir_pc
);
    import fe_pkg::*;

    logic [xlen-1:0]     pc;
    logic [credit_w-1:0] credits;
    logic                running;
    logic                epoch;

    // Outstanding reads, oldest at trk_rd
    logic [xlen-1:0]     trk_pc    [max_in_flight];
    logic                trk_epoch [max_in_flight];
    logic [trk_aw-1:0]   trk_wr;
    logic [trk_aw-1:0]   trk_rd;
    logic [trk_aw:0]     trk_cnt;

    logic                issue;
    logic                ret_good;
    logic                ret_stale;

    assign f_req  = running && (credits != '0) &&
                    (trk_cnt < (trk_aw+1)'(max_in_flight));
    assign f_addr = pc;
    assign issue  = f_gnt;

    // A return from an old epoch, or one that meets a redirect, is dropped
    assign ret_good  = f_rvalid && (trk_epoch[trk_rd] == epoch) && !redir_valid;
    assign ret_stale = f_rvalid && !ret_good;

    assign pd_inst = f_rdata;
    assign pd_pc   = trk_pc[trk_rd];

    assign q_push    = ret_good;
    assign q_inst    = f_rdata;
    assign q_pc      = trk_pc[trk_rd];
    assign q_br_type = pd_br_type;
    assign q_pred_pc = pd_pred_pc;

    //////////////////////////////////////////////////////////////////////
    // PC, epoch and credit bookkeeping
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= reset_pc;
            credits <= credit_w'(queue_depth);
            running <= 1'b0;
            epoch   <= 1'b0;
            trk_wr  <= '0;
            trk_rd  <= '0;
            trk_cnt <= '0;
        end else begin
            running <= 1'b1;
            // Spend at issue, refund on squash or when the queue frees a slot
            credits <= credits - credit_w'(issue) + credit_w'(ret_stale)
                       + credit_w'(q_credit);
            trk_cnt <= trk_cnt + (trk_aw+1)'(issue) - (trk_aw+1)'(f_rvalid);
            if (issue) begin
                trk_wr <= trk_wr + trk_aw'(1);
            end
            if (f_rvalid) begin
                trk_rd <= trk_rd + trk_aw'(1);
            end
            if (redir_valid) begin
                pc    <= redir_pc;
                epoch <= ~epoch;
            end else if (ret_good && pd_redirect) begin
                pc    <= pd_pred_pc;
                epoch <= ~epoch;
            end else if (issue) begin
                pc <= pc + xlen'(4);
            end
        end
    end

    // Tracking slots, written at issue
    always_ff @(posedge clk) begin
        if (issue) begin
            trk_pc[trk_wr]    <= pc;
            trk_epoch[trk_wr] <= epoch;
        end
    end

endmodule

`default_nettype wire

//--- design/frontend_top.sv
`default_nettype none

module frontend_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         ld_req,
    input  logic [fe_pkg::xlen-1:0]      ld_addr,
    input  logic [fe_pkg::xlen-1:0]      ld_data,
    input  logic                         redir_valid,
    input  logic [fe_pkg::xlen-1:0]      redir_pc,
    output logic                         out_valid,
    output logic [fe_pkg::xlen-1:0]      out_inst,
    output logic [fe_pkg::xlen-1:0]      out_pc,
    output logic [fe_pkg::br_type_w-1:0] out_br_type,
    output logic [fe_pkg::xlen-1:0]      out_pred_pc,
    input  logic                         dn_credit
);
    import fe_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Interconnect
    //////////////////////////////////////////////////////////////////////

    logic                 f_req, f_gnt, f_rvalid;
    logic [xlen-1:0]      f_addr, f_rdata;
    logic                 mem_en, mem_we;
    logic [mem_aw-1:0]    mem_addr;
    logic [xlen-1:0]      mem_wdata, mem_rdata;
    logic [xlen-1:0]      pd_inst, pd_pc, pd_pred_pc;
    logic [br_type_w-1:0] pd_br_type;
    logic                 pd_redirect;
    logic                 q_push, q_credit;
    logic [xlen-1:0]      q_inst, q_pc, q_pred_pc;
    logic [br_type_w-1:0] q_br_type;

    imem_arbiter i_arb (
        .clk, .rst, .ld_req, .ld_addr, .ld_data,
        .f_req, .f_addr, .f_gnt, .f_rvalid, .f_rdata,
        .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
    );

    inst_mem i_mem (
        .clk, .mem_en, .mem_we, .mem_addr, .mem_wdata, .mem_rdata
    );

    fetch_unit i_fetch (
        .clk, .rst, .f_req, .f_addr, .f_gnt, .f_rvalid, .f_rdata,
        .pd_inst, .pd_pc, .pd_br_type, .pd_pred_pc, .pd_redirect,
        .q_push, .q_inst, .q_pc, .q_br_type, .q_pred_pc, .q_credit,
        .redir_valid, .redir_pc
    );

    pre_decoder i_pd (
        .pd_inst, .pd_pc, .pd_br_type, .pd_pred_pc, .pd_redirect
    );

    // A back-end redirect also empties the queue
    fetch_queue i_queue (
        .clk, .rst, .q_push, .q_inst, .q_pc, .q_br_type, .q_pred_pc, .q_credit,
        .flush(redir_valid),
        .out_valid, .out_inst, .out_pc, .out_br_type, .out_pred_pc, .dn_credit
    );

endmodule

`default_nettype wire

//--- design/imem_arbiter.sv
`default_nettype none

module imem_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    // Loader, write only
    input  logic                      ld_req,
    input  logic [fe_pkg::xlen-1:0]   ld_addr,
    input  logic [fe_pkg::xlen-1:0]   ld_data,
    // Fetch unit, read only
    input  logic                      f_req,
    input  logic [fe_pkg::xlen-1:0]   f_addr,
    output logic                      f_gnt,
    output logic                      f_rvalid,
    output logic [fe_pkg::xlen-1:0]   f_rdata,
    // Memory port
    output logic                      mem_en,
    output logic                      mem_we,
    output logic [fe_pkg::mem_aw-1:0] mem_addr,
    output logic [fe_pkg::xlen-1:0]   mem_wdata,
    input  logic [fe_pkg::xlen-1:0]   mem_rdata
);
    import fe_pkg::*;

    logic rd_fetch;

    // Loader always wins the port
    assign f_gnt = f_req & ~ld_req;

    assign mem_en    = ld_req | f_req;
    assign mem_we    = ld_req;
    // Byte addresses in, word addresses out
    assign mem_addr  = ld_req ? ld_addr[mem_aw+1:2] : f_addr[mem_aw+1:2];
    assign mem_wdata = ld_data;

    // Marks that the word on mem_rdata belongs to the fetch unit
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_fetch <= 1'b0;
        end else begin
            rd_fetch <= f_gnt;
        end
    end

    assign f_rvalid = rd_fetch;
    assign f_rdata  = mem_rdata;

endmodule

`default_nettype wire

//--- design/inst_mem.sv
`default_nettype none

module inst_mem (
    input  logic                      clk,
    input  logic                      mem_en,
    input  logic                      mem_we,
    input  logic [fe_pkg::mem_aw-1:0] mem_addr,
    input  logic [fe_pkg::xlen-1:0]   mem_wdata,
    output logic [fe_pkg::xlen-1:0]   mem_rdata
);
    import fe_pkg::*;

    logic [xlen-1:0] ram [mem_words];

    //////////////////////////////////////////////////////////////////////
    // Single port, write at the edge, registered read
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                ram[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= ram[mem_addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/pre_decoder.sv
`default_nettype none

module pre_decoder (
    input  logic [fe_pkg::xlen-1:0]      pd_inst,
    input  logic [fe_pkg::xlen-1:0]      pd_pc,
    output logic [fe_pkg::br_type_w-1:0] pd_br_type,
    output logic [fe_pkg::xlen-1:0]      pd_pred_pc,
    output logic                         pd_redirect
);
    import fe_pkg::*;

    logic [op_w-1:0] opcode;
    logic [xlen-1:0] imm16;
    logic [xlen-1:0] imm26;
    logic [xlen-1:0] target;
    logic [xlen-1:0] seq_pc;
    logic            is_uncond;
    logic            is_cond;

    assign opcode = pd_inst[31:26];

    //////////////////////////////////////////////////////////////////////
    // Branch classification
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            op_beq:  pd_br_type = br_beq;
            op_bne:  pd_br_type = br_bne;
            op_blt:  pd_br_type = br_blt;
            op_bge:  pd_br_type = br_bge;
            op_bltu: pd_br_type = br_bltu;
            op_bgeu: pd_br_type = br_bgeu;
            op_b:    pd_br_type = br_b;
            op_bl:   pd_br_type = br_bl;
            op_jirl: pd_br_type = br_jirl;
            default: pd_br_type = br_none;
        endcase
    end

    assign is_uncond = (pd_br_type == br_b) || (pd_br_type == br_bl);
    assign is_cond   = (pd_br_type >= br_beq) && (pd_br_type <= br_bgeu);

    //////////////////////////////////////////////////////////////////////
    // Offsets and target
    //////////////////////////////////////////////////////////////////////

    // offs16 in bits 25:10
    assign imm16 = {{14{pd_inst[25]}}, pd_inst[25:10], 2'b00};
    // offs26 split, high part in bits 9:0
    assign imm26 = {{4{pd_inst[9]}}, pd_inst[9:0], pd_inst[25:10], 2'b00};

    assign target = pd_pc + (is_uncond ? imm26 : imm16);
    assign seq_pc = pd_pc + xlen'(4);

    // Static rule: b and bl taken, backward conditional taken, jirl fall through
    always_comb begin
        if (is_uncond) begin
            pd_pred_pc = target;
        end else if (is_cond && imm16[xlen-1]) begin
            pd_pred_pc = target;
        end else begin
            pd_pred_pc = seq_pc;
        end
    end

    assign pd_redirect = (pd_pred_pc != seq_pc);

endmodule

`default_nettype wire

//--- sim.f
design/fe_pkg.sv
design/imem_arbiter.sv
design/inst_mem.sv
design/fetch_unit.sv
design/pre_decoder.sv
design/fetch_queue.sv
design/frontend_top.sv
bench/frontend_checker.sv
bench/frontend_tb.sv
